/* source/busCfgPkg.sv */
package busCfgPkg;

  //////////////////////////////////////////////////
  // Fixed configuration of the bus data path
  //////////////////////////////////////////////////

  // One bus word per beat and the data cache works in the same width
  localparam int XLEN = 32;

  // Physical addresses are as wide as the word in this configuration
  localparam int PA_BITS = 32;

  // A cache line is four bus words, so every line transfer takes four beats
  localparam int WORDSPERLINE = 4;

  // Width of the beat index that walks through the words of a line
  localparam int LOGWPL = $clog2(WORDSPERLINE);

  // The whole line as one flat vector with word 0 in the low bits
  localparam int LINELEN = XLEN * WORDSPERLINE;

  // Byte offset of a word inside the line, used to step the address per beat
  localparam int BYTEOFFSET = $clog2(XLEN / 8);

  //////////////////////////////////////////////////
  // Vector types with a meaning of their own
  //////////////////////////////////////////////////

  // A single word as it appears on the read or write data lines
  typedef logic [XLEN-1:0] busWordT;

  // A byte address on the bus
  typedef logic [PA_BITS-1:0] physAdrT;

  // A full line as collected by the fetch buffer
  typedef logic [LINELEN-1:0] lineT;

  // Index of the current beat within a line transfer
  typedef logic [LOGWPL-1:0] wordCountT;

  // Access size code in the funct3 encoding
  // Code 0 is a byte, 1 a halfword and 2 a full word
  typedef logic [2:0] accessSizeT;

  // Line transfers always move whole words
  localparam accessSizeT SIZEWORD = 3'b010;

endpackage

/* source/busCtrlPkg.sv */
package busCtrlPkg;

  //////////////////////////////////////////////////
  // Bus sequencer states
  //////////////////////////////////////////////////

  // Ready waits for work from the cache or the load/store unit
  // The Uncached states carry one single access straight to the bus
  // UncachedReadDone keeps the fetched word visible until the CPU takes it
  // LineFetch and LineWrite walk through all words of a line
  // LineDone is the one idle cycle after a line transfer
  typedef enum logic [2:0] {
    Ready,
    UncachedRead,
    UncachedWrite,
    UncachedReadDone,
    LineFetch,
    LineWrite,
    LineDone
  } busStateT;

  //////////////////////////////////////////////////
  // Request bundles
  //////////////////////////////////////////////////

  // Line request from the data cache
  // Both levels stay high until the cache sees cacheBusAck
  typedef struct packed {
    busCfgPkg::physAdrT adr;
    logic               fetchLine;
    logic               writeLine;
  } cacheReqT;

  // Access from the load/store unit
  // Bit 1 of rw asks for a read and bit 0 for a write
  typedef struct packed {
    busCfgPkg::physAdrT    adr;
    logic [1:0]            rw;
    busCfgPkg::accessSizeT funct3;
    busCfgPkg::busWordT    storeData;
    logic                  cacheable;
  } lsuReqT;

  // Request toward the next level of memory
  // Read and write are levels that hold until busAck
  typedef struct packed {
    busCfgPkg::physAdrT    adr;
    busCfgPkg::accessSizeT size;
    busCfgPkg::busWordT    wdata;
    logic                  read;
    logic                  write;
  } busReqT;

endpackage

/* source/busFsm.sv */
module busFsm (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 ignoreRequest,
  input  logic [1:0]           lsuRw,
  input  logic                 cacheable,
  input  logic                 fetchLine,
  input  logic                 writeLine,
  input  logic                 busAck,
  input  logic                 cpuBusy,
  output logic                 busRead,
  output logic                 busWrite,
  output logic                 cacheBusAck,
  output logic                 busStall,
  output logic                 busCommitted,
  output logic                 selUncached,
  output busCfgPkg::wordCountT wordCount
);
  import busCfgPkg::*;
  import busCtrlPkg::*;

  busStateT state;
  busStateT stateNext;
  logic     uncachedReq;
  logic     lineActive;
  logic     lastBeat;

  // An access bypasses the cache when it reads or writes and is not cacheable
  assign uncachedReq = (|lsuRw) & ~cacheable;

  // Both line states step the word counter on every ack
  assign lineActive = (state == LineFetch) || (state == LineWrite);

  // The beat that finishes a line
  assign lastBeat = (wordCount == wordCountT'(WORDSPERLINE - 1));

  //////////////////////////////////////////////////
  // State register and next state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= Ready;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      Ready: begin
        // Uncached traffic goes first, then a victim writeback, then a fill
        // A dirty victim has to leave before the fill reuses its line
        if (!ignoreRequest) begin
          if (uncachedReq) begin
            stateNext = lsuRw[1] ? UncachedRead : UncachedWrite;
          end else if (writeLine) begin
            stateNext = LineWrite;
          end else if (fetchLine) begin
            stateNext = LineFetch;
          end
        end
      end
      UncachedRead: begin
        if (busAck) begin
          stateNext = UncachedReadDone;
        end
      end
      UncachedReadDone: begin
        // The word stays on readDataWordMux until the pipeline moves on
        if (!cpuBusy) begin
          stateNext = Ready;
        end
      end
      UncachedWrite: begin
        if (busAck) begin
          stateNext = Ready;
        end
      end
      LineFetch, LineWrite: begin
        if (busAck && lastBeat) begin
          stateNext = LineDone;
        end
      end
      LineDone: begin
        stateNext = Ready;
      end
      default: begin
        stateNext = Ready;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Word counter
  //////////////////////////////////////////////////

  // Uncached accesses never move the counter so they always use word 0
  // The counter wraps to zero on the final beat of a line
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wordCount <= '0;
    end else if (lineActive && busAck) begin
      if (lastBeat) begin
        wordCount <= '0;
      end else begin
        wordCount <= wordCount + wordCountT'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs decoded from the state
  //////////////////////////////////////////////////

  // Read and write rise in the cycle after the start and hold until the ack
  assign busRead  = (state == UncachedRead) || (state == LineFetch);
  assign busWrite = (state == UncachedWrite) || (state == LineWrite);

  // The cache learns of the finished line in the same cycle as the last ack
  assign cacheBusAck = lineActive & busAck & lastBeat;

  // The pipeline may run on while the uncached word waits and in LineDone
  assign busStall = (state != Ready) && (state != UncachedReadDone) && (state != LineDone);

  // Any state past Ready means the bus has taken the access
  assign busCommitted = (state != Ready);

  // Steers the address, size and data muxes to the load/store unit side
  assign selUncached = (state == UncachedRead) || (state == UncachedWrite) ||
                       (state == UncachedReadDone);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Only one direction can be active on the bus at a time
  aBusOneDir : assert property (@(posedge clk) disable iff (!rstN)
    !(busRead && busWrite))
    else $error("busFsm read and write both high");

  // The beat index only changes when memory completes a beat
  aCountNeedsAck : assert property (@(posedge clk) disable iff (!rstN)
    !busAck |=> $stable(wordCount))
    else $error("busFsm wordCount moved without busAck");

  // The line ack comes with the final beat and is followed by LineDone
  aLineAckEnds : assert property (@(posedge clk) disable iff (!rstN)
    cacheBusAck |-> busAck ##1 (state == LineDone && wordCount == '0))
    else $error("busFsm cacheBusAck outside the last beat of a line");

endmodule

/* source/busDp.sv */
module busDp (
  input  logic                 clk,
  input  logic                 rstN,
  input  busCtrlPkg::cacheReqT cacheReq,
  input  busCtrlPkg::lsuReqT   lsuReq,
  input  busCfgPkg::busWordT   writeWord,
  input  busCfgPkg::busWordT   readDataWord,
  input  logic                 ignoreRequest,
  input  logic                 cpuBusy,
  input  busCfgPkg::busWordT   busRdata,
  input  logic                 busAck,
  output busCtrlPkg::busReqT   busReq,
  output busCfgPkg::wordCountT wordCount,
  output busCfgPkg::lineT      lineData,
  output busCfgPkg::busWordT   readDataWordMux,
  output logic                 cacheBusAck,
  output logic                 busStall,
  output logic                 busCommitted
);
  import busCfgPkg::*;

  logic    selUncached;
  logic    busRead;
  logic    busWrite;
  physAdrT baseAdr;

  //////////////////////////////////////////////////
  // Fetch buffer
  //////////////////////////////////////////////////

  // Each word of the line has its own register
  // A register loads only on the read ack of the beat that matches its index
  // An uncached read lands in word 0 because the counter stays at zero
  for (genvar i = 0; i < WORDSPERLINE; i++) begin : fetchBuf
    busWordT fetchWord;

    always_ff @(posedge clk) begin
      if (busAck && busRead && (wordCount == wordCountT'(i))) begin
        fetchWord <= busRdata;
      end
    end

    assign lineData[i*XLEN +: XLEN] = fetchWord;
  end

  //////////////////////////////////////////////////
  // Address, size and data muxes
  //////////////////////////////////////////////////

  // Uncached accesses use the load/store unit address as is
  // Line transfers start at the line base from the cache
  assign baseAdr = selUncached ? lsuReq.adr : cacheReq.adr;

  // Each beat moves one word further into the line
  assign busReq.adr = baseAdr + (physAdrT'(wordCount) << BYTEOFFSET);

  // Single accesses keep their own size and line beats are always full words
  assign busReq.size = selUncached ? lsuReq.funct3 : SIZEWORD;

  // Store data for uncached writes and the victim word during a writeback
  // Atomic results arrive already merged into the store data
  assign busReq.wdata = selUncached ? lsuReq.storeData : writeWord;

  assign busReq.read  = busRead;
  assign busReq.write = busWrite;

  // The uncached word comes out of the fetch buffer and hits come from the cache
  assign readDataWordMux = selUncached ? lineData[XLEN-1:0] : readDataWord;

  //////////////////////////////////////////////////
  // Bus sequencer
  //////////////////////////////////////////////////

  busFsm uBusFsm (
    .clk          (clk),
    .rstN         (rstN),
    .ignoreRequest(ignoreRequest),
    .lsuRw        (lsuReq.rw),
    .cacheable    (lsuReq.cacheable),
    .fetchLine    (cacheReq.fetchLine),
    .writeLine    (cacheReq.writeLine),
    .busAck       (busAck),
    .cpuBusy      (cpuBusy),
    .busRead      (busRead),
    .busWrite     (busWrite),
    .cacheBusAck  (cacheBusAck),
    .busStall     (busStall),
    .busCommitted (busCommitted),
    .selUncached  (selUncached),
    .wordCount    (wordCount)
  );

  // While memory holds off the ack the request must not move under it
  // This ties the sequencer state to the mux selects and the counter
  aAdrHolds : assert property (@(posedge clk) disable iff (!rstN)
    (busReq.read || busReq.write) && !busAck |=> $stable(busReq.adr) && $stable(busReq.size))
    else $error("busDp address or size changed while waiting for busAck");

endmodule

/* dv/busTb.sv */
module busTb;
  timeunit 1ns;
  timeprecision 100ps;
  import busCfgPkg::*;
  import busCtrlPkg::*;

  // One expected bus beat where the data only matters for writes
  typedef struct packed {
    physAdrT    adr;
    accessSizeT size;
    busWordT    data;
    logic       write;
    logic       last;
  } beatT;

  logic      clk;
  logic      rstN;
  cacheReqT  cacheReq;
  lsuReqT    lsuReq;
  busWordT   writeWord;
  busWordT   readDataWord;
  logic      ignoreRequest;
  logic      cpuBusy;
  busWordT   busRdata;
  logic      busAck;
  busReqT    busReq;
  wordCountT wordCount;
  lineT      lineData;
  busWordT   readDataWordMux;
  logic      cacheBusAck;
  logic      busStall;
  logic      busCommitted;

  integer  seed;
  int      errors = 0;
  int      tests = 0;
  int      waitLeft = -1;
  logic    waiting = 1'b0;
  busReqT  heldReq;
  busWordT shadow [physAdrT];
  beatT    expQ [$];

  busDp dut0 (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Memory content is the address rotated left by 7 unless a store replaced it
  function automatic busWordT memWord(physAdrT adr);
    if (shadow.exists(adr)) return shadow[adr];
    return {adr[24:0], adr[31:25]} ^ 32'h5a5a0000;
  endfunction

  // Victim word the cache offers for a given beat of a writeback
  function automatic busWordT victimWord(physAdrT base, wordCountT wc);
    return ~base ^ {16'hd00d, 14'h0, wc};
  endfunction

  // The cache picks its victim word from wordCount
  always @(negedge clk) writeWord = victimWord(cacheReq.adr, wordCount);

  // Memory acks after 0 to 3 wait cycles and keeps the ack for one cycle
  always @(negedge clk) begin
    if (!rstN || busAck) begin
      busAck = 1'b0;
      waitLeft = -1;
    end else if (busReq.read || busReq.write) begin
      if (waitLeft < 0) waitLeft = $random(seed) & 3;
      if (waitLeft == 0) begin
        busAck = 1'b1;
        if (busReq.read) busRdata = memWord(busReq.adr);
      end else begin
        waitLeft--;
      end
    end
  end

  // Memory takes the write data at the clock edge that ends the beat
  always @(posedge clk) begin
    if (rstN && busAck && busReq.write && busReq.size == SIZEWORD)
      shadow[busReq.adr] = busReq.wdata;
  end

  task automatic reportError(string msg);
    $display("ERROR %0t: %0s", $time, msg);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Beat comparison
  //////////////////////////////////////////////////

  // Values are taken at the rising edge before the DUT registers update
  always @(posedge clk) begin
    beatT exp;
    if (rstN) begin
      if (waiting && (busReq.adr !== heldReq.adr || busReq.wdata !== heldReq.wdata ||
                      busReq.size !== heldReq.size))
        reportError($sformatf("request moved before ack, adr %h was %h",
                              busReq.adr, heldReq.adr));
      if (busAck && (busReq.read || busReq.write)) begin
        if (!busStall || !busCommitted)
          reportError("busStall or busCommitted low during a bus beat");
        if (expQ.size() == 0) begin
          reportError($sformatf("unexpected bus beat at adr %h", busReq.adr));
        end else begin
          exp = expQ.pop_front();
          if (busReq.adr !== exp.adr || busReq.size !== exp.size ||
              busReq.write !== exp.write || cacheBusAck !== exp.last ||
              (exp.write && busReq.wdata !== exp.data))
            reportError($sformatf(
              "beat adr %h size %0d wr %b data %h last %b, expected %h %0d %b %h %b",
              busReq.adr, busReq.size, busReq.write, busReq.wdata, cacheBusAck,
              exp.adr, exp.size, exp.write, exp.data, exp.last));
        end
      end else if (cacheBusAck) begin
        reportError("cacheBusAck without a bus ack");
      end
      waiting = (busReq.read || busReq.write) && !busAck;
      heldReq = busReq;
    end
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  task automatic finishRun();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  endtask

  task automatic giveUp(string what);
    $display("Timeout while waiting for %0s, the DUT stopped responding", what);
    errors++;
    finishRun();
  endtask

  task automatic endTest(string name, int errBefore);
    tests++;
    $display("Test %-24s %0s", name, (errors == errBefore) ? "passed" : "FAILED");
  endtask

  // Returns on the falling edge once the comparer has consumed enough beats
  task automatic waitQueueLen(int left);
    int cycles = 0;
    while (expQ.size() > left) begin
      @(negedge clk);
      cycles++;
      if (cycles > 80) giveUp("bus beats");
    end
  endtask

  task automatic waitIdle();
    int cycles = 0;
    while (busCommitted) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) giveUp("return to Ready");
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic checkIdle(string name);
    int errBefore = errors;
    readDataWord = 32'h3c3c1e1e;
    repeat (4) begin
      @(posedge clk);
      if (busReq.read || busReq.write || busStall || busCommitted || cacheBusAck)
        reportError("DUT not idle");
      if (wordCount !== '0) reportError($sformatf("wordCount %0d, expected 0", wordCount));
      if (readDataWordMux !== readDataWord)
        reportError($sformatf("readDataWordMux %h, expected %h", readDataWordMux, readDataWord));
    end
    @(negedge clk);
    cacheReq.fetchLine = 1'b0;
    ignoreRequest = 1'b0;
    endTest(name, errBefore);
  endtask

  // Writeback goes first when both levels are high and the fill then reads the new words
  task automatic lineTransfer(string name, physAdrT base, logic doWrite, logic doFetch);
    int      errBefore = errors;
    busWordT expWords [WORDSPERLINE];
    for (int i = 0; i < WORDSPERLINE; i++) begin
      expWords[i] = memWord(base + physAdrT'(4 * i));
      if (doWrite) begin
        expWords[i] = victimWord(base, wordCountT'(i));
        expQ.push_back(beatT'{base + physAdrT'(4 * i), SIZEWORD, expWords[i], 1'b1,
                              i == WORDSPERLINE - 1});
      end
    end
    if (doFetch)
      for (int i = 0; i < WORDSPERLINE; i++)
        expQ.push_back(beatT'{base + physAdrT'(4 * i), SIZEWORD, '0, 1'b0,
                              i == WORDSPERLINE - 1});
    cacheReq = cacheReqT'{base, doFetch, doWrite};
    if (doWrite) begin
      waitQueueLen(doFetch ? WORDSPERLINE : 0);
      cacheReq.writeLine = 1'b0;
    end
    if (doFetch) begin
      waitQueueLen(0);
      cacheReq.fetchLine = 1'b0;
      for (int i = 0; i < WORDSPERLINE; i++)
        if (lineData[i*XLEN +: XLEN] !== expWords[i])
          reportError($sformatf("lineData word %0d is %h, expected %h", i,
                                lineData[i*XLEN +: XLEN], expWords[i]));
    end
    waitIdle();
    endTest(name, errBefore);
  endtask

  task automatic uncachedRead(physAdrT adr, accessSizeT f3);
    int errBefore = errors;
    expQ.push_back(beatT'{adr, f3, '0, 1'b0, 1'b0});
    lsuReq = lsuReqT'{adr, 2'b10, f3, 32'h0, 1'b0};
    cpuBusy = 1'b1;
    waitQueueLen(0);
    // The word stays visible for as long as the CPU is busy
    repeat (3) begin
      if (readDataWordMux !== memWord(adr))
        reportError($sformatf("uncached word %h, expected %h", readDataWordMux, memWord(adr)));
      if (busStall || !busCommitted) reportError("busStall high or bus not committed in read done");
      @(negedge clk);
    end
    lsuReq.rw = 2'b00;
    cpuBusy = 1'b0;
    waitIdle();
    endTest("uncached read", errBefore);
  endtask

  task automatic uncachedWrite(physAdrT adr, busWordT data, accessSizeT f3);
    int errBefore = errors;
    expQ.push_back(beatT'{adr, f3, data, 1'b1, 1'b0});
    lsuReq = lsuReqT'{adr, 2'b01, f3, data, 1'b0};
    waitQueueLen(0);
    lsuReq.rw = 2'b00;
    waitIdle();
    endTest("uncached write", errBefore);
  endtask

  initial begin
    seed = 32'hbd8c6627;
    rstN = 1'b0;
    cacheReq = '0;
    lsuReq = '0;
    writeWord = '0;
    readDataWord = '0;
    ignoreRequest = 1'b0;
    cpuBusy = 1'b0;
    busRdata = '0;
    busAck = 1'b0;
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    checkIdle("reset state");
    lineTransfer("line fill", 32'h00001000, 1'b0, 1'b1);
    lineTransfer("line writeback", 32'h00002040, 1'b1, 1'b0);
    lineTransfer("fill after writeback", 32'h00002040, 1'b0, 1'b1);
    uncachedRead(32'h80000124, 3'b010);
    uncachedWrite(32'h80000200, 32'hfeed5a17, 3'b001);
    lineTransfer("writeback before fill", 32'h00003080, 1'b1, 1'b1);
    // A held fetch must not start while requests are ignored
    ignoreRequest = 1'b1;
    cacheReq = cacheReqT'{32'h00004000, 1'b1, 1'b0};
    checkIdle("ignored request");
    if (expQ.size() != 0) reportError($sformatf("%0d expected beats never came", expQ.size()));
    finishRun();
  end

endmodule

/* busDp.f */
source/busCfgPkg.sv
source/busCtrlPkg.sv
source/busFsm.sv
source/busDp.sv
dv/busTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f busDp.f --top-module busTb -o busTbSim &&
  ./obj_dir/busTbSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log 2>/dev/null && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
